// File: sources.f
design/video_frame_pkg.sv
design/dma_control_slave.sv
design/frame_reader.sv
design/pixel_writer.sv
design/memory_arbiter.sv
design/frame_memory.sv
design/video_frame_top.sv
sim/tb_video_frame.sv

// File: Bender.yml
package:
  name: video_frame

sources:
  - files:
      - design/video_frame_pkg.sv
      - design/dma_control_slave.sv
      - design/frame_reader.sv
      - design/pixel_writer.sv
      - design/memory_arbiter.sv
      - design/frame_memory.sv
      - design/video_frame_top.sv
  - target: simulation
    files:
      - sim/tb_video_frame.sv

// File: sim/tb_video_frame.sv
`timescale 1ns/1ps

module tb_video_frame import video_frame_pkg::*;
();

	localparam int NUM_FRAMES     = 4;
	localparam int MAX_DRAWS      = FRAME_WORDS * (NUM_FRAMES + 1);
	localparam int TIMEOUT_CYCLES = NUM_FRAMES * FRAME_WORDS * 4 + MAX_DRAWS * 8 + 2000;

	logic       clk;
	logic       reset;
	reg_bus_t   bus;
	logic       enable;
	logic       draw;
	coord_x_t   draw_x;
	coord_y_t   draw_y;
	pixel_t     draw_color;
	reg_data_t  readdata;
	logic       busy;
	pixel_out_t pixel_out;

	logic [31:0]  lfsr = 32'hb1c63bad;
	reg_data_t    model_front;
	reg_data_t    model_back;
	logic         model_swap;
	pixel_t       model_mem [MEM_WORDS];
	bit           model_known [MEM_WORDS];
	int           pix_index;
	int           frames_seen;
	logic         end_seen;
	logic         wr_front;
	logic         wr_back;
	reg_data_t    wr_data;
	byte_enable_t wr_be;

	video_frame_top i_dut (
		.clk        (clk),
		.reset      (reset),
		.bus        (bus),
		.enable     (enable),
		.draw       (draw),
		.draw_x     (draw_x),
		.draw_y     (draw_y),
		.draw_color (draw_color),
		.readdata   (readdata),
		.busy       (busy),
		.pixel_out  (pixel_out)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial
	begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles.", TIMEOUT_CYCLES);
		$display("** FAIL **");
		$fatal(1, "Watchdog expired.");
	end

	//////////////////////////////////////////////////////////////////////
	// Random numbers and checks
	//////////////////////////////////////////////////////////////////////

	// Galois LFSR stepped once per bit taken.
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return r;
	endfunction

	function automatic reg_data_t status_word(input logic swap);
		return {ADDRESSING_BITS, 4'h0, COLOR_BITS, COLOR_PLANES, 4'h0, ADDRESSING_MODE, swap};
	endfunction

	task automatic stop_run();
		$display("** FAIL **");
		$fatal(1, "Stopped at the first error.");
	endtask

	task automatic report_failure(input string what);
		$display("Error at %0t ns: %s", $time, what);
		stop_run();
	endtask

	task automatic check_reg(input string name, input reg_data_t got, input reg_data_t exp);
		if (got !== exp)
		begin
			$display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_pixel(input string name, input pixel_t got, input pixel_t exp);
		if (got !== exp)
		begin
			$display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_coord(input coord_x_t got_x, input coord_y_t got_y,
		input coord_x_t exp_x, input coord_y_t exp_y);
		if (got_x !== exp_x || got_y !== exp_y)
		begin
			$display("** Error at %0t ns: pixel_out.x/y is %0d/%0d, expected %0d/%0d",
				$time, got_x, got_y, exp_x, exp_y);
			stop_run();
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Model and cycle stepping
	//////////////////////////////////////////////////////////////////////

	// Effects of the coming rising edge on the register model.
	task automatic apply_edge();
		reg_data_t mask;
		mask = {{8{wr_be[3]}}, {8{wr_be[2]}}, {8{wr_be[1]}}, {8{wr_be[0]}}};
		if (wr_back)
			model_back = (model_back & ~mask) | (wr_data & mask);
		if (end_seen)
		begin
			if (model_swap && !wr_back)
				{model_front, model_back} = {model_back, model_front};
			model_swap = 1'b0;
		end
		if (wr_front)
			model_swap = 1'b1;
		wr_front = 1'b0;
		wr_back  = 1'b0;
		end_seen = 1'b0;
	endtask

	task automatic observe_pixel();
		mem_addr_t word;
		if (pixel_out.valid === 1'b1)
		begin
			check_coord(pixel_out.x, pixel_out.y, coord_x_t'(pix_index % FRAME_WIDTH),
				coord_y_t'(pix_index / FRAME_WIDTH));
			word = mem_addr_t'(model_front[11:2] + pix_index);
			if (model_known[word])
				check_pixel("pixel_out.color", pixel_out.color, model_mem[word]);
			if (pixel_out.last !== (pix_index == FRAME_WORDS - 1))
				report_failure($sformatf("pixel_out.last is wrong on pixel %0d", pix_index));
			end_seen  = pixel_out.last;
			pix_index = end_seen ? 0 : pix_index + 1;
			if (end_seen)
				frames_seen++;
		end
	endtask

	task automatic next_cycle();
		apply_edge();
		@(negedge clk);
		bus  = '0;
		draw = 1'b0;
		observe_pixel();
	endtask

	task automatic read_reg(input reg_addr_t index, input reg_data_t exp, input string name);
		bus.address = index;
		bus.read    = 1'b1;
		next_cycle();
		check_reg(name, readdata, exp);
	endtask

	task automatic write_reg(input reg_addr_t index, input reg_data_t data,
		input byte_enable_t be);
		bus.address    = index;
		bus.byteenable = be;
		bus.write      = 1'b1;
		bus.writedata  = data;
		wr_front       = (index == 2'd0);
		wr_back        = (index == 2'd1);
		wr_data        = data;
		wr_be          = be;
		next_cycle();
	endtask

	// Caller makes sure busy is low, so the draw is taken at the next edge.
	task automatic draw_pixel(input coord_x_t x, input coord_y_t y, input pixel_t color);
		mem_addr_t word;
		word = mem_addr_t'(model_back[11:2] + y * FRAME_WIDTH + x);
		model_mem[word]   = color;
		model_known[word] = 1'b1;
		draw       = 1'b1;
		draw_x     = x;
		draw_y     = y;
		draw_color = color;
	endtask

	task automatic run_frames(input int count);
		int       target;
		coord_x_t x;
		coord_y_t y;
		pixel_t   color;
		target = frames_seen + count;
		while (frames_seen < target)
		begin
			if (!busy && rand_bits(1))
			begin
				x     = coord_x_t'(rand_bits(4));
				y     = coord_y_t'(rand_bits(3));
				color = pixel_t'(rand_bits(16));
				draw_pixel(x, y, color);
			end
			next_cycle();
		end
		// Let the frame-end edge land before any register access.
		next_cycle();
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		reg_data_t    data;
		byte_enable_t be;
		reset       = 1'b1;
		bus         = '0;
		enable      = 1'b0;
		draw        = 1'b0;
		draw_x      = '0;
		draw_y      = '0;
		draw_color  = '0;
		model_front = DEFAULT_FRONT_ADDRESS;
		model_back  = DEFAULT_BACK_ADDRESS;
		model_swap  = 1'b0;
		pix_index   = 0;
		frames_seen = 0;
		end_seen    = 1'b0;
		wr_front    = 1'b0;
		wr_back     = 1'b0;
		wr_data     = '0;
		wr_be       = '0;
		repeat (4) @(negedge clk);
		reset = 1'b0;

		if (busy !== 1'b0 || pixel_out.valid !== 1'b0)
			report_failure("busy or pixel_out.valid is not clear after reset");
		check_reg("readdata", readdata, '0);
		read_reg(2'd0, DEFAULT_FRONT_ADDRESS, "readdata (front)");
		read_reg(2'd1, DEFAULT_BACK_ADDRESS, "readdata (back)");
		read_reg(2'd2, {16'd8, 16'd16}, "readdata (size)");
		read_reg(2'd3, status_word(1'b0), "readdata (status)");

		for (int i = 0; i < 6; i++)
		begin
			data = rand_bits(32);
			be   = byte_enable_t'(rand_bits(4));
			write_reg(2'd1, data, be);
			read_reg(2'd1, model_back, "readdata (back)");
		end
		write_reg(2'd1, DEFAULT_BACK_ADDRESS, 4'hf);
		write_reg(2'd0, rand_bits(32), 4'hf);
		read_reg(2'd3, status_word(1'b1), "readdata (status)");

		// Fill the back buffer before any frame runs.
		for (int i = 0; i < FRAME_WORDS; i++)
		begin
			while (busy)
				next_cycle();
			draw_pixel(coord_x_t'(i % FRAME_WIDTH), coord_y_t'(i / FRAME_WIDTH),
				pixel_t'(rand_bits(16)));
			next_cycle();
		end

		enable = 1'b1;
		run_frames(1);
		read_reg(2'd0, DEFAULT_BACK_ADDRESS, "readdata (front)");
		read_reg(2'd1, DEFAULT_FRONT_ADDRESS, "readdata (back)");
		read_reg(2'd3, status_word(1'b0), "readdata (status)");

		run_frames(1);
		read_reg(2'd0, DEFAULT_BACK_ADDRESS, "readdata (front)");
		read_reg(2'd1, DEFAULT_FRONT_ADDRESS, "readdata (back)");

		write_reg(2'd0, rand_bits(32), 4'hf);
		run_frames(1);
		read_reg(2'd0, DEFAULT_FRONT_ADDRESS, "readdata (front)");
		read_reg(2'd1, DEFAULT_BACK_ADDRESS, "readdata (back)");
		read_reg(2'd3, status_word(1'b0), "readdata (status)");

		// Streams the pixels drawn during the previous two frames.
		run_frames(1);
		$display("** PASS **");
		$finish;
	end

endmodule

// File: design/video_frame_top.sv
`timescale 1ns/1ps

module video_frame_top import video_frame_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  reg_bus_t   bus,
	input  logic       enable,
	input  logic       draw,
	input  coord_x_t   draw_x,
	input  coord_y_t   draw_y,
	input  pixel_t     draw_color,
	output reg_data_t  readdata,
	output logic       busy,
	output pixel_out_t pixel_out
);

	reg_data_t front_address;
	reg_data_t back_address;
	logic      frame_done;
	mem_req_t  reader_req;
	mem_req_t  writer_req;
	mem_req_t  mem_cmd;
	logic      reader_grant;
	logic      writer_grant;
	pixel_t    mem_rdata;

	//////////////////////////////////////////////////////////////////////
	// Control and masters
	//////////////////////////////////////////////////////////////////////

	dma_control_slave i_slave (
		.clk           (clk),
		.reset         (reset),
		.bus           (bus),
		.frame_done    (frame_done),
		.readdata      (readdata),
		.front_address (front_address),
		.back_address  (back_address)
	);

	frame_reader i_reader (
		.clk           (clk),
		.reset         (reset),
		.enable        (enable),
		.front_address (front_address),
		.grant         (reader_grant),
		.mem_rdata     (mem_rdata),
		.mem_req       (reader_req),
		.pixel_out     (pixel_out),
		.frame_done    (frame_done)
	);

	pixel_writer i_writer (
		.clk          (clk),
		.reset        (reset),
		.draw         (draw),
		.draw_x       (draw_x),
		.draw_y       (draw_y),
		.draw_color   (draw_color),
		.back_address (back_address),
		.grant        (writer_grant),
		.busy         (busy),
		.mem_req      (writer_req)
	);

	//////////////////////////////////////////////////////////////////////
	// Shared memory port
	//////////////////////////////////////////////////////////////////////

	memory_arbiter i_arbiter (
		.clk          (clk),
		.reset        (reset),
		.reader_req   (reader_req),
		.writer_req   (writer_req),
		.reader_grant (reader_grant),
		.writer_grant (writer_grant),
		.mem_cmd      (mem_cmd)
	);

	frame_memory i_memory (
		.clk   (clk),
		.cmd   (mem_cmd),
		.rdata (mem_rdata)
	);

endmodule

// File: design/frame_memory.sv
`timescale 1ns/1ps

module frame_memory import video_frame_pkg::*;
(
	input  logic     clk,
	input  mem_req_t cmd,
	output pixel_t   rdata
);

	pixel_t mem [MEM_WORDS];

	// Single port, read data one cycle after the request.
	always_ff @(posedge clk)
	begin
		if (cmd.req)
		begin
			if (cmd.we)
				mem[cmd.addr] <= cmd.wdata;
			else
				rdata <= mem[cmd.addr];
		end
	end

endmodule

// File: design/memory_arbiter.sv
`timescale 1ns/1ps

module memory_arbiter import video_frame_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  mem_req_t reader_req,
	input  mem_req_t writer_req,
	output logic     reader_grant,
	output logic     writer_grant,
	output mem_req_t mem_cmd
);

	// Set when the writer won the last grant.
	logic last_writer;

	//////////////////////////////////////////////////////////////////////
	// Round-robin grant
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		reader_grant = 1'b0;
		writer_grant = 1'b0;
		if (reader_req.req && writer_req.req)
		begin
			reader_grant = last_writer;
			writer_grant = ~last_writer;
		end
		else
		begin
			reader_grant = reader_req.req;
			writer_grant = writer_req.req;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			last_writer <= 1'b0;
		else if (reader_grant)
			last_writer <= 1'b0;
		else if (writer_grant)
			last_writer <= 1'b1;
	end

	// Winner goes straight to the memory port.
	always_comb
	begin
		if (reader_grant)
			mem_cmd = reader_req;
		else if (writer_grant)
			mem_cmd = writer_req;
		else
			mem_cmd = '0;
	end

endmodule

// File: design/pixel_writer.sv
`timescale 1ns/1ps

module pixel_writer import video_frame_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      draw,
	input  coord_x_t  draw_x,
	input  coord_y_t  draw_y,
	input  pixel_t    draw_color,
	input  reg_data_t back_address,
	input  logic      grant,
	output logic      busy,
	output mem_req_t  mem_req
);

	logic      pending;
	logic      accept;
	mem_addr_t write_addr;
	pixel_t    write_color;

	assign accept = draw & ~pending;
	assign busy   = pending;

	assign mem_req.req   = pending;
	assign mem_req.we    = 1'b1;
	assign mem_req.addr  = write_addr;
	assign mem_req.wdata = write_color;

	// One write outstanding at a time.
	always_ff @(posedge clk)
	begin
		if (reset)
			pending <= 1'b0;
		else if (accept)
			pending <= 1'b1;
		else if (grant)
			pending <= 1'b0;
	end

	// Raster offset y * FRAME_WIDTH + x is the concatenation {y, x}.
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			write_addr  <= back_address[11:2] + mem_addr_t'({draw_y, draw_x});
			write_color <= draw_color;
		end
	end

endmodule

// File: design/frame_reader.sv
`timescale 1ns/1ps

module frame_reader import video_frame_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       enable,
	input  reg_data_t  front_address,
	input  logic       grant,
	input  pixel_t     mem_rdata,
	output mem_req_t   mem_req,
	output pixel_out_t pixel_out,
	output logic       frame_done
);

	reader_state_t state;
	mem_addr_t     base;
	coord_x_t      fetch_x;
	coord_y_t      fetch_y;
	logic          fetch_last;

	// Tag of the fetch whose word is on mem_rdata.
	logic          tag_valid;
	coord_x_t      tag_x;
	coord_y_t      tag_y;
	logic          tag_last;

	assign fetch_last = (fetch_x == coord_x_t'(FRAME_WIDTH - 1)) &&
		(fetch_y == coord_y_t'(FRAME_HEIGHT - 1));

	assign mem_req.req   = (state == READER_FETCH);
	assign mem_req.we    = 1'b0;
	assign mem_req.addr  = base + mem_addr_t'({fetch_y, fetch_x});
	assign mem_req.wdata = '0;

	assign frame_done = pixel_out.valid & pixel_out.last;

	//////////////////////////////////////////////////////////////////////
	// Fetch FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state   <= READER_IDLE;
			fetch_x <= '0;
			fetch_y <= '0;
		end
		else
		begin
			case (state)
				READER_IDLE:
					if (enable)
					begin
						state   <= READER_FETCH;
						fetch_x <= '0;
						fetch_y <= '0;
					end
				READER_FETCH:
					if (grant)
					begin
						{fetch_y, fetch_x} <= {fetch_y, fetch_x} + 1'b1;
						if (fetch_last)
							state <= READER_DRAIN;
					end
				default:
					if (frame_done)
						state <= READER_IDLE;
			endcase
		end
	end

	// Base is taken only when leaving IDLE, so a mid-frame swap has no effect.
	always_ff @(posedge clk)
	begin
		if (state == READER_IDLE && enable)
			base <= front_address[11:2];
	end

	//////////////////////////////////////////////////////////////////////
	// Tag and output pipeline
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			tag_valid       <= 1'b0;
			pixel_out.valid <= 1'b0;
		end
		else
		begin
			tag_valid       <= grant;
			pixel_out.valid <= tag_valid;
		end
	end

	always_ff @(posedge clk)
	begin
		tag_x           <= fetch_x;
		tag_y           <= fetch_y;
		tag_last        <= fetch_last;
		pixel_out.x     <= tag_x;
		pixel_out.y     <= tag_y;
		pixel_out.color <= mem_rdata;
		pixel_out.last  <= tag_last & tag_valid;
	end

endmodule

// File: design/dma_control_slave.sv
`timescale 1ns/1ps

module dma_control_slave import video_frame_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  reg_bus_t  bus,
	input  logic      frame_done,
	output reg_data_t readdata,
	output reg_data_t front_address,
	output reg_data_t back_address
);

	logic swap_pending;
	logic write_front;
	logic write_back;

	assign write_front = bus.write & (bus.address == 2'd0);
	assign write_back  = bus.write & (bus.address == 2'd1);

	//////////////////////////////////////////////////////////////////////
	// Register read
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
			readdata <= '0;
		else if (bus.read)
		begin
			case (bus.address)
				2'd0: readdata <= front_address;
				2'd1: readdata <= back_address;
				2'd2: readdata <= {16'(FRAME_HEIGHT), 16'(FRAME_WIDTH)};
				default:
					readdata <= {ADDRESSING_BITS, 4'h0, COLOR_BITS, COLOR_PLANES,
						4'h0, ADDRESSING_MODE, swap_pending};
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Buffer addresses and swap
	//////////////////////////////////////////////////////////////////////

	// A back-address write beats an exchange in the same cycle.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			front_address <= DEFAULT_FRONT_ADDRESS;
			back_address  <= DEFAULT_BACK_ADDRESS;
		end
		else if (write_back)
		begin
			for (int i = 0; i < 4; i++)
			begin
				if (bus.byteenable[i])
					back_address[i*8 +: 8] <= bus.writedata[i*8 +: 8];
			end
		end
		else if (swap_pending & frame_done)
		begin
			front_address <= back_address;
			back_address  <= front_address;
		end
	end

	// Frame end clears the request, unless the host asks again right then.
	always_ff @(posedge clk)
	begin
		if (reset)
			swap_pending <= 1'b0;
		else if (write_front)
			swap_pending <= 1'b1;
		else if (frame_done)
			swap_pending <= 1'b0;
	end

endmodule

// File: design/video_frame_pkg.sv
package video_frame_pkg;

	//////////////////////////////////////////////////////////////////////
	// Basic widths
	//////////////////////////////////////////////////////////////////////

	typedef logic [31:0] reg_data_t;
	typedef logic [1:0]  reg_addr_t;
	typedef logic [3:0]  byte_enable_t;

	// Word address, bits 11:2 of a buffer byte address.
	typedef logic [9:0]  mem_addr_t;

	// One pixel per memory word.
	typedef logic [15:0] pixel_t;
	typedef logic [3:0]  coord_x_t;
	typedef logic [2:0]  coord_y_t;

	//////////////////////////////////////////////////////////////////////
	// Resolution, memory and format
	//////////////////////////////////////////////////////////////////////

	localparam int FRAME_WIDTH  = 16;
	localparam int FRAME_HEIGHT = 8;
	localparam int FRAME_WORDS  = FRAME_WIDTH * FRAME_HEIGHT;
	localparam int MEM_WORDS    = 1024;

	localparam reg_data_t DEFAULT_FRONT_ADDRESS = 32'h0000_0000;
	localparam reg_data_t DEFAULT_BACK_ADDRESS  = 32'h0000_0200;

	localparam logic [15:0] ADDRESSING_BITS = 16'h0407;
	localparam logic [3:0]  COLOR_BITS      = 4'hf;     // 16-bit color
	localparam logic [1:0]  COLOR_PLANES    = 2'h1;
	localparam logic        ADDRESSING_MODE = 1'b0;     // Consecutive.

	//////////////////////////////////////////////////////////////////////
	// Shared structs and enums
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		reg_addr_t    address;
		byte_enable_t byteenable;
		logic         read;
		logic         write;
		reg_data_t    writedata;
	} reg_bus_t;

	typedef struct packed {
		logic      req;
		logic      we;
		mem_addr_t addr;
		pixel_t    wdata;
	} mem_req_t;

	typedef struct packed {
		logic     valid;
		coord_x_t x;
		coord_y_t y;
		pixel_t   color;
		logic     last;
	} pixel_out_t;

	typedef enum logic [1:0] {
		READER_IDLE,
		READER_FETCH,
		READER_DRAIN
	} reader_state_t;

endpackage
